//--- design/aud_rec_pkg.sv
package aud_rec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and recording depth
    ////////////////////////////////////////////////////////////

    // One codec word per channel per frame
    localparam int SAMPLE_W = 16;

    // Word address of the external SRAM
    localparam int ADDR_W = 20;

    // Words per recording, must fit in ADDR_W
    localparam int REC_DEPTH = 1024000;

    ////////////////////////////////////////////////////////////
    // Bundles passed between stages
    ////////////////////////////////////////////////////////////

    // One-cycle command pulses from the button conditioner
    typedef struct packed {
        logic start;
        logic pause;
        logic stop;
    } aud_cmd_t;

    // Left-channel word with its one-cycle strobe
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] data;
    } aud_sample_t;

    // SRAM write port, we is a one-cycle strobe
    typedef struct packed {
        logic                we;
        logic [ADDR_W-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } sram_wr_t;

endpackage

//--- design/aud_cmd_edge.sv
`timescale 1ns/1ps

module aud_cmd_edge (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_pause,
    input  logic                  i_stop,
    output aud_rec_pkg::aud_cmd_t o_cmd
);
    import aud_rec_pkg::*;

    aud_cmd_t btn_w;
    aud_cmd_t pin_r;
    aud_cmd_t meta_r;
    aud_cmd_t sync_r;
    aud_cmd_t prev_r;
    aud_cmd_t cmd_r, cmd_w;

    assign o_cmd = cmd_r;

    always_comb begin
        btn_w.start = i_start;
        btn_w.pause = i_pause;
        btn_w.stop  = i_stop;
        // A command fires when the button is let go
        cmd_w       = prev_r & ~sync_r;
    end

    ////////////////////////////////////////////////////////////
    // Pin register, two-flop synchronizer and release detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            pin_r  <= '0;
            meta_r <= '0;
            sync_r <= '0;
            prev_r <= '0;
            cmd_r  <= '0;
        end
        else begin
            pin_r  <= btn_w;
            meta_r <= pin_r;
            sync_r <= meta_r;
            prev_r <= sync_r;
            cmd_r  <= cmd_w;
        end
    end

endmodule

//--- design/i2s_left_deser.sv
`timescale 1ns/1ps

module i2s_left_deser (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_lrc,
    input  logic                     i_data,
    output aud_rec_pkg::aud_sample_t o_sample
);
    import aud_rec_pkg::*;

    // Counts left-half bits, saturates once the word is complete
    logic [$clog2(SAMPLE_W+1)-1:0] cnt_r, cnt_w;
    logic [SAMPLE_W-1:0]           shift_r, shift_w;
    logic [SAMPLE_W-1:0]           word_r, word_w;
    logic                          valid_r, valid_w;

    assign o_sample = '{valid: valid_r, data: word_r};

    ////////////////////////////////////////////////////////////
    // Left half shifting
    ////////////////////////////////////////////////////////////

    always_comb begin
        cnt_w   = cnt_r;
        shift_w = shift_r;
        word_w  = word_r;
        valid_w = 1'b0;
        if (i_lrc) begin
            // Right half, get ready for the next frame
            cnt_w = '0;
        end
        else if (cnt_r < SAMPLE_W) begin
            // MSB arrives first and ends up in the top bit
            shift_w = {shift_r[SAMPLE_W-2:0], i_data};
            cnt_w   = cnt_r + 1'b1;
            if (cnt_r == SAMPLE_W - 1) begin
                word_w  = shift_w;
                valid_w = 1'b1;
            end
        end
        // Filler bits past the word fall through here
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            cnt_r   <= '0;
            valid_r <= 1'b0;
        end
        else begin
            cnt_r   <= cnt_w;
            valid_r <= valid_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
        word_r  <= word_w;
    end

endmodule

//--- design/rec_sequencer.sv
`timescale 1ns/1ps

module rec_sequencer #(
    parameter int P_DEPTH = aud_rec_pkg::REC_DEPTH
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  aud_rec_pkg::aud_cmd_t    i_cmd,
    input  aud_rec_pkg::aud_sample_t i_sample,
    output aud_rec_pkg::sram_wr_t    o_wr,
    output logic                     o_finish
);
    import aud_rec_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REC,
        S_PAUSE,
        S_FINISH
    } rec_state_t;

    rec_state_t          state_r, state_w;
    logic [ADDR_W-1:0]   addr_r, addr_w;
    logic                finish_r, finish_w;
    logic                we_r, we_w;
    logic [ADDR_W-1:0]   wr_addr_r, wr_addr_w;
    logic [SAMPLE_W-1:0] wr_data_r, wr_data_w;

    assign o_wr     = '{we: we_r, addr: wr_addr_r, data: wr_data_r};
    assign o_finish = finish_r;

    ////////////////////////////////////////////////////////////
    // Record FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_w   = state_r;
        addr_w    = addr_r;
        finish_w  = finish_r;
        we_w      = 1'b0;
        wr_addr_w = wr_addr_r;
        wr_data_w = wr_data_r;
        case (state_r)
            S_IDLE, S_FINISH: begin
                if (i_cmd.start) begin
                    state_w  = S_REC;
                    addr_w   = '0;
                    finish_w = 1'b0;
                end
            end
            S_REC: begin
                // Stop takes priority over a sample in the same cycle
                if (i_cmd.stop) begin
                    state_w  = S_FINISH;
                    finish_w = 1'b1;
                end
                else if (i_cmd.pause) begin
                    state_w = S_PAUSE;
                end
                else if (i_sample.valid) begin
                    we_w      = 1'b1;
                    wr_addr_w = addr_r;
                    wr_data_w = i_sample.data;
                    addr_w    = addr_r + 1'b1;
                    // Last word of the recording closes it on its own
                    if (addr_r == ADDR_W'(P_DEPTH - 1)) begin
                        state_w  = S_FINISH;
                        finish_w = 1'b1;
                    end
                end
            end
            S_PAUSE: begin
                if (i_cmd.stop) begin
                    state_w  = S_FINISH;
                    finish_w = 1'b1;
                end
                else if (i_cmd.pause) begin
                    state_w = S_REC;
                end
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r  <= S_IDLE;
            addr_r   <= '0;
            finish_r <= 1'b0;
            we_r     <= 1'b0;
        end
        else begin
            state_r  <= state_w;
            addr_r   <= addr_w;
            finish_r <= finish_w;
            we_r     <= we_w;
        end
    end

    // SRAM address and data hold between writes
    always_ff @(posedge i_clk) begin
        wr_addr_r <= wr_addr_w;
        wr_data_r <= wr_data_w;
    end

endmodule

//--- design/aud_recorder_top.sv
`timescale 1ns/1ps

module aud_recorder_top #(
    parameter int P_DEPTH = aud_rec_pkg::REC_DEPTH
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_lrc,
    input  logic                             i_data,
    input  logic                             i_start,
    input  logic                             i_pause,
    input  logic                             i_stop,
    output logic [aud_rec_pkg::ADDR_W-1:0]   o_sram_addr,
    output logic [aud_rec_pkg::SAMPLE_W-1:0] o_sram_data,
    output logic                             o_sram_we,
    output logic                             o_finish
);
    import aud_rec_pkg::*;

    aud_cmd_t    cmd;
    aud_sample_t sample;
    sram_wr_t    wr;

    aud_cmd_edge i_aud_cmd_edge (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_pause (i_pause),
        .i_stop  (i_stop),
        .o_cmd   (cmd)
    );

    i2s_left_deser i_i2s_left_deser (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_lrc    (i_lrc),
        .i_data   (i_data),
        .o_sample (sample)
    );

    rec_sequencer #(
        .P_DEPTH (P_DEPTH)
    ) i_rec_sequencer (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_cmd    (cmd),
        .i_sample (sample),
        .o_wr     (wr),
        .o_finish (o_finish)
    );

    // SRAM pins
    assign o_sram_addr = wr.addr;
    assign o_sram_data = wr.data;
    assign o_sram_we   = wr.we;

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int P_PERIOD_NS  = 8,
    parameter int P_RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(P_PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // Reset is high while asserted and drops just after a rising edge
    initial begin
        o_rst_n = 1'b1;
        repeat (P_RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b0;
    end

endmodule

//--- verification/tb_aud_recorder.sv
`timescale 1ns/1ps

module tb_aud_recorder;
    import aud_rec_pkg::*;

    typedef enum int {BTN_NONE, BTN_START, BTN_PAUSE, BTN_STOP} btn_t;

    localparam int DEPTH        = 8;
    localparam int FRAME_CYCLES = 40;
    localparam int N_FRAMES     = 34;
    localparam int TIMEOUT_NS   = 2 * N_FRAMES * FRAME_CYCLES * 8;

    logic                clk;
    logic                rst_n;
    logic                lrc;
    logic                sdata;
    logic                start;
    logic                pause;
    logic                stop;
    logic [ADDR_W-1:0]   sram_addr;
    logic [SAMPLE_W-1:0] sram_data;
    logic                sram_we;
    logic                finish;

    integer seed = 61;
    int     next_addr;

    logic [ADDR_W+SAMPLE_W-1:0] wr_q[$];
    logic [ADDR_W+SAMPLE_W-1:0] exp_q[$];

    tb_clk_gen #(.P_PERIOD_NS(8), .P_RST_CYCLES(8)) i_tb_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    aud_recorder_top #(.P_DEPTH(DEPTH)) i_aud_recorder_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_lrc       (lrc),
        .i_data      (sdata),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .o_sram_addr (sram_addr),
        .o_sram_data (sram_data),
        .o_sram_we   (sram_we),
        .o_finish    (finish)
    );

    // Every SRAM write seen on the pins is sampled mid-cycle
    always @(negedge clk) begin
        if (sram_we === 1'b1)
            wr_q.push_back({sram_addr, sram_data});
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and checking helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic random_bit();
        random_bit = $random(seed) & 1;
    endfunction

    task automatic drive_bit(input logic lrc_v, input logic data_v);
        @(posedge clk);
        #1;
        lrc   = lrc_v;
        sdata = data_v;
    endtask

    task automatic press_button(input btn_t btn);
        @(posedge clk);
        #1;
        case (btn)
            BTN_START: start = 1'b1;
            BTN_PAUSE: pause = 1'b1;
            BTN_STOP:  stop  = 1'b1;
            default:   ;
        endcase
        repeat (4) @(posedge clk);
        #1;
        start = 1'b0;
        pause = 1'b0;
        stop  = 1'b0;
    endtask

    // Left half carries the word MSB first and then filler bits
    // The button is pressed and released during the right half
    task automatic send_frame(input logic [SAMPLE_W-1:0] word, input int left_len,
                              input btn_t btn);
        for (int i = 0; i < left_len; i++) begin
            if (i < SAMPLE_W)
                drive_bit(1'b0, word[SAMPLE_W-1-i]);
            else
                drive_bit(1'b0, random_bit());
        end
        fork
            begin
                for (int i = 0; i < FRAME_CYCLES / 2; i++)
                    drive_bit(1'b1, random_bit());
            end
            begin
                if (btn != BTN_NONE)
                    press_button(btn);
            end
        join
    endtask

    task automatic expect_write(input logic [SAMPLE_W-1:0] word);
        exp_q.push_back({ADDR_W'(next_addr), word});
        next_addr++;
    endtask

    task automatic compare_writes();
        logic [ADDR_W+SAMPLE_W-1:0] act;
        logic [ADDR_W+SAMPLE_W-1:0] exp;
        check("o_sram_we count", wr_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            act = wr_q[i];
            exp = exp_q[i];
            check("o_sram_addr", act[ADDR_W+SAMPLE_W-1:SAMPLE_W],
                  exp[ADDR_W+SAMPLE_W-1:SAMPLE_W]);
            check("o_sram_data", act[SAMPLE_W-1:0], exp[SAMPLE_W-1:0]);
        end
        wr_q.delete();
        exp_q.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        logic [SAMPLE_W-1:0] w;
        for (int f = 0; f < 3; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
            check("o_finish", finish, 0);
        end
        compare_writes();
    endtask

    task automatic capture_frames();
        logic [SAMPLE_W-1:0] w;
        // This frame's word arrives before the start and is dropped
        w = $random(seed);
        send_frame(w, 20, BTN_START);
        next_addr = 0;
        for (int f = 0; f < 5; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
            expect_write(w);
            check("o_finish", finish, 0);
        end
        compare_writes();
    endtask

    task automatic stop_and_restart();
        logic [SAMPLE_W-1:0] w;
        w = $random(seed);
        send_frame(w, 20, BTN_STOP);
        expect_write(w);
        check("o_finish", finish, 1);
        for (int f = 0; f < 2; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
            check("o_finish", finish, 1);
        end
        w = $random(seed);
        send_frame(w, 20, BTN_START);
        check("o_finish", finish, 0);
        next_addr = 0;
        w = $random(seed);
        send_frame(w, 20, BTN_NONE);
        expect_write(w);
        compare_writes();
    endtask

    task automatic pause_and_resume();
        logic [SAMPLE_W-1:0] w;
        w = $random(seed);
        send_frame(w, 20, BTN_PAUSE);
        expect_write(w);
        for (int f = 0; f < 2; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
        end
        // Resume comes after this frame's word, so the word is dropped
        w = $random(seed);
        send_frame(w, 20, BTN_PAUSE);
        for (int f = 0; f < 2; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
            expect_write(w);
        end
        check("o_finish", finish, 0);
        compare_writes();
    endtask

    task automatic short_left_half();
        logic [SAMPLE_W-1:0] w;
        w = $random(seed);
        send_frame(w, 12, BTN_NONE);
        w = $random(seed);
        send_frame(w, 20, BTN_NONE);
        expect_write(w);
        compare_writes();
    endtask

    task automatic depth_limit();
        logic [SAMPLE_W-1:0] w;
        w = $random(seed);
        send_frame(w, 20, BTN_STOP);
        expect_write(w);
        w = $random(seed);
        send_frame(w, 20, BTN_START);
        next_addr = 0;
        for (int f = 0; f < 10; f++) begin
            w = $random(seed);
            send_frame(w, 20, BTN_NONE);
            if (f < DEPTH)
                expect_write(w);
            check("o_finish", finish, f >= DEPTH - 1);
        end
        compare_writes();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not complete in the expected time");
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        lrc       = 1'b1;
        sdata     = 1'b0;
        start     = 1'b0;
        pause     = 1'b0;
        stop      = 1'b0;
        next_addr = 0;
        wait (rst_n === 1'b0);
        idle_after_reset();
        capture_frames();
        stop_and_restart();
        pause_and_resume();
        short_left_half();
        depth_limit();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
design/aud_rec_pkg.sv
design/aud_cmd_edge.sv
design/i2s_left_deser.sv
design/rec_sequencer.sv
design/aud_recorder_top.sv
verification/tb_clk_gen.sv
verification/tb_aud_recorder.sv

//--- Bender.yml
package:
  name: aud_recorder

sources:
  - files:
      - design/aud_rec_pkg.sv
      - design/aud_cmd_edge.sv
      - design/i2s_left_deser.sv
      - design/rec_sequencer.sv
      - design/aud_recorder_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_aud_recorder.sv
